// File: exu_data_pkg.sv
// Data-path widths, PC type, register and CSR index types, access-size type

package exu_data_pkg;

  // ----------------------------------------------------------
  // Widths and constants
  // ----------------------------------------------------------

  // Default integer register width, RV64
  localparam int DATA_WIDTH_DEFAULT = 64;

  // Sequential PC increment, no compressed instructions
  localparam int PC_STEP = 4;

  // ----------------------------------------------------------
  // Scalar types
  // ----------------------------------------------------------

  // Fetch address space is 32 bits wide
  typedef logic [31:0] pc_t;

  // Integer register file index, x0..x31
  typedef logic [4:0] gpr_idx_t;

  // CSR address as encoded in the instruction
  typedef logic [11:0] csr_idx_t;

  // Memory access size, log2 of the byte count
  typedef enum logic [1:0] {
    LS_BYTE   = 2'd0,
    LS_HALF   = 2'd1,
    LS_WORD   = 2'd2,
    LS_DOUBLE = 2'd3
  } ls_size_e;

endpackage

// File: exu_isa_pkg.sv
// Instruction encodings: ALU, branch, jump, CSR and load/store codes, load/store union

package exu_isa_pkg;

  // ----------------------------------------------------------
  // Integer ALU operations
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    ALU_NOP   = 4'd0,
    ALU_ADD   = 4'd1,
    ALU_SUB   = 4'd2,
    ALU_SLT   = 4'd3,
    ALU_SLTU  = 4'd4,
    ALU_AND   = 4'd5,
    ALU_OR    = 4'd6,
    ALU_XOR   = 4'd7,
    ALU_SLL   = 4'd8,
    ALU_SRL   = 4'd9,
    ALU_SRA   = 4'd10,
    ALU_LUI   = 4'd11,
    ALU_AUIPC = 4'd12
  } alu_op_e;

  // Conditional branch, 0 means no branch
  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_BEQ  = 3'd1,
    BR_BNE  = 3'd2,
    BR_BLT  = 3'd3,
    BR_BGE  = 3'd4,
    BR_BLTU = 3'd5,
    BR_BGEU = 3'd6
  } br_type_e;

  // Unconditional jumps
  typedef enum logic [1:0] {
    JMP_NONE = 2'd0,
    JMP_JAL  = 2'd1,
    JMP_JALR = 2'd2
  } jmp_type_e;

  // CSR write forms, the I forms take the zimm in imm
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3,
    CSR_RWI  = 3'd4,
    CSR_RSI  = 3'd5,
    CSR_RCI  = 3'd6
  } csr_type_e;

  // ----------------------------------------------------------
  // Load/store codes
  // ----------------------------------------------------------

  // Stores all sit at 8 and above
  typedef enum logic [3:0] {
    LS_NONE = 4'd0,
    LS_LB   = 4'd1,
    LS_LBU  = 4'd2,
    LS_LH   = 4'd3,
    LS_LHU  = 4'd4,
    LS_LW   = 4'd5,
    LS_LWU  = 4'd6,
    LS_LD   = 4'd7,
    LS_SB   = 4'd8,
    LS_SH   = 4'd9,
    LS_SW   = 4'd10,
    LS_SD   = 4'd11
  } ls_code_e;

  // Direction view of the same code
  typedef struct packed {
    logic       is_store;
    logic [2:0] idx;
  } ls_dir_t;

  // Size decode reads code, direction logic reads dir
  typedef union packed {
    ls_code_e code;
    ls_dir_t  dir;
  } ls_word_u;

endpackage

// File: exu_issue_if.sv
// Issue interface carrying one decoded instruction, with one modport per unit

`timescale 1ns/1ps

interface exu_issue_if
  import exu_data_pkg::*;
  import exu_isa_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_WIDTH_DEFAULT
) ();

  // Strobe and operands
  logic                  vld;
  pc_t                   pc;
  logic [DATA_WIDTH-1:0] rs1;
  logic [DATA_WIDTH-1:0] rs2;
  logic [DATA_WIDTH-1:0] imm;
  logic                  src2_imm;
  logic                  word_op;

  // Decoded class, only one is non-zero per instruction
  alu_op_e               alu_op;
  br_type_e              br_type;
  jmp_type_e             jmp_type;
  ls_word_u              ls_type;
  csr_type_e             csr_type;

  // Old CSR value and destinations
  logic [DATA_WIDTH-1:0] csr_data;
  gpr_idx_t              rd_idx;
  csr_idx_t              csr_idx;

  // Class fields feed the exclusivity check in arith
  modport arith (input vld, pc, rs1, rs2, imm, src2_imm, word_op, alu_op,
                 br_type, jmp_type, ls_type, csr_type);
  modport branch (input vld, pc, rs1, rs2, imm, br_type, jmp_type);
  modport lsu (input vld, rs1, rs2, imm, ls_type, rd_idx);
  modport csr (input vld, rs1, imm, csr_type, csr_data, csr_idx);
  modport wb (input vld, alu_op, jmp_type, csr_type, csr_data, rd_idx);

endinterface

// File: int_arith.sv
// Integer ALU datapath: add/sub, compare, logic, shifts, lui, auipc and W forms

`timescale 1ns/1ps

module int_arith
  import exu_data_pkg::*;
  import exu_isa_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_WIDTH_DEFAULT
) (
  exu_issue_if.arith           iss,
  output logic [DATA_WIDTH-1:0] arith_result
);

  logic [DATA_WIDTH-1:0] op_b;
  logic [DATA_WIDTH-1:0] op_b_eff;
  logic                  do_sub;
  logic [DATA_WIDTH:0]   sum_ext;
  logic                  lt_s;
  logic                  lt_u;
  logic [5:0]            shamt;
  logic [DATA_WIDTH-1:0] sll_d;
  logic [DATA_WIDTH-1:0] srl_d;
  logic [DATA_WIDTH-1:0] sra_d;
  logic [31:0]           srl_w;
  logic [31:0]           sra_w;
  logic [DATA_WIDTH-1:0] raw;

  // ----------------------------------------------------------
  // Shared adder
  // ----------------------------------------------------------

  // Immediate replaces rs2 for the I forms
  assign op_b = iss.src2_imm ? iss.imm : iss.rs2;

  // Compares run through the subtractor too
  assign do_sub   = iss.alu_op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
  assign op_b_eff = do_sub ? ~op_b : op_b;
  assign sum_ext  = {1'b0, iss.rs1} + {1'b0, op_b_eff} + {{DATA_WIDTH{1'b0}}, do_sub};

  // No carry out of a - b means a below b, unsigned
  assign lt_u = ~sum_ext[DATA_WIDTH];

  // Signs differ: rs1 sign decides, else difference sign
  assign lt_s = (iss.rs1[DATA_WIDTH-1] != op_b[DATA_WIDTH-1]) ? iss.rs1[DATA_WIDTH-1]
                                                             : sum_ext[DATA_WIDTH-1];

  // ----------------------------------------------------------
  // Shifter
  // ----------------------------------------------------------

  // W forms only take five bits of shift amount
  assign shamt = iss.word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

  assign sll_d = iss.rs1 << shamt;
  assign srl_d = iss.rs1 >> shamt;
  assign sra_d = $signed(iss.rs1) >>> shamt;

  // Right shifts in W form work on the low word only
  assign srl_w = iss.rs1[31:0] >> shamt[4:0];
  assign sra_w = $signed(iss.rs1[31:0]) >>> shamt[4:0];

  // ----------------------------------------------------------
  // Result select
  // ----------------------------------------------------------
  always_comb begin
    case (iss.alu_op)
      ALU_ADD,
      ALU_SUB:   raw = sum_ext[DATA_WIDTH-1:0];
      ALU_SLT:   raw = DATA_WIDTH'(lt_s);
      ALU_SLTU:  raw = DATA_WIDTH'(lt_u);
      ALU_AND:   raw = iss.rs1 & op_b;
      ALU_OR:    raw = iss.rs1 | op_b;
      ALU_XOR:   raw = iss.rs1 ^ op_b;
      // Low word of the wide left shift is already right
      ALU_SLL:   raw = sll_d;
      ALU_SRL:   raw = iss.word_op ? DATA_WIDTH'(srl_w) : srl_d;
      ALU_SRA:   raw = iss.word_op ? DATA_WIDTH'(sra_w) : sra_d;
      ALU_LUI:   raw = iss.imm;
      ALU_AUIPC: raw = iss.imm + DATA_WIDTH'(iss.pc);
      default:   raw = '0;
    endcase
  end

  // W forms sign-extend bit 31 of the word result
  assign arith_result = iss.word_op ? {{(DATA_WIDTH-32){raw[31]}}, raw[31:0]} : raw;

  // Decoder marks each instruction with one class only
  always_comb begin
    if (iss.vld && iss.alu_op != ALU_NOP) begin
      assert final (iss.br_type == BR_NONE && iss.jmp_type == JMP_NONE &&
                    iss.ls_type.code == LS_NONE && iss.csr_type == CSR_NONE)
        else $error("ALU op issued together with another class");
    end
  end

endmodule

// File: branch_unit.sv
// Branch condition check, jump target adder and next-PC select

`timescale 1ns/1ps

module branch_unit
  import exu_data_pkg::*;
  import exu_isa_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_WIDTH_DEFAULT
) (
  exu_issue_if.branch iss,
  output logic        jump_en,
  output pc_t         next_pc,
  output pc_t         link_pc
);

  logic                  eq;
  logic                  lt_s;
  logic                  lt_u;
  logic                  taken;
  logic [DATA_WIDTH-1:0] jalr_sum;
  pc_t                   target;

  // ----------------------------------------------------------
  // Condition
  // ----------------------------------------------------------
  assign eq   = iss.rs1 == iss.rs2;
  assign lt_s = $signed(iss.rs1) < $signed(iss.rs2);
  assign lt_u = iss.rs1 < iss.rs2;

  always_comb begin
    case (iss.br_type)
      BR_BEQ:  taken = eq;
      BR_BNE:  taken = ~eq;
      BR_BLT:  taken = lt_s;
      BR_BGE:  taken = ~lt_s;
      BR_BLTU: taken = lt_u;
      BR_BGEU: taken = ~lt_u;
      default: taken = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // Target and next PC
  // ----------------------------------------------------------

  // JALR keeps bit 0 of the sum as is
  assign jalr_sum = iss.rs1 + iss.imm;
  assign target   = (iss.jmp_type == JMP_JALR) ? jalr_sum[31:0]
                                               : iss.pc + iss.imm[31:0];

  // Return address, also the fall-through PC
  assign link_pc = iss.pc + pc_t'(PC_STEP);

  assign jump_en = iss.vld & (taken | (iss.jmp_type != JMP_NONE));

  // Idle cycles drive zero
  always_comb begin
    if (!iss.vld)
      next_pc = '0;
    else if (jump_en)
      next_pc = target;
    else
      next_pc = link_pc;
  end

endmodule

// File: lsu_agen.sv
// Load/store address generation, misalignment flags and registered LSU command

`timescale 1ns/1ps

module lsu_agen
  import exu_data_pkg::*;
  import exu_isa_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_WIDTH_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rstn,
  exu_issue_if.lsu              iss,
  output logic                  l_misa,
  output logic                  s_misa,
  output logic                  lsu_vld,
  output logic                  lsu_wen,
  output pc_t                   lsu_addr,
  output logic [DATA_WIDTH-1:0] lsu_wdata,
  output ls_code_e              lsu_ls_type,
  output gpr_idx_t              lsu_rd_idx
);

  logic [DATA_WIDTH-1:0] addr_sum;
  pc_t                   addr;
  ls_size_e              size;
  logic                  misa;
  logic                  acc_vld;

  // ----------------------------------------------------------
  // Address and alignment
  // ----------------------------------------------------------
  assign addr_sum = iss.rs1 + iss.imm;
  assign addr     = addr_sum[31:0];

  always_comb begin
    case (iss.ls_type.code)
      LS_LH, LS_LHU, LS_SH: size = LS_HALF;
      LS_LW, LS_LWU, LS_SW: size = LS_WORD;
      LS_LD, LS_SD:         size = LS_DOUBLE;
      default:              size = LS_BYTE;
    endcase
  end

  // Byte accesses never misalign
  always_comb begin
    case (size)
      LS_HALF:   misa = addr[0];
      LS_WORD:   misa = |addr[1:0];
      LS_DOUBLE: misa = |addr[2:0];
      default:   misa = 1'b0;
    endcase
  end

  assign acc_vld = iss.vld & (iss.ls_type.code != LS_NONE);

  // Direction comes from the top bit of the code
  assign l_misa = acc_vld & misa & ~iss.ls_type.dir.is_store;
  assign s_misa = acc_vld & misa & iss.ls_type.dir.is_store;

  // ----------------------------------------------------------
  // Command register
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lsu_vld <= 1'b0;
      lsu_wen <= 1'b0;
    end else begin
      lsu_vld <= acc_vld;
      if (acc_vld)
        lsu_wen <= iss.ls_type.dir.is_store;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_vld) begin
      lsu_addr    <= addr;
      lsu_ls_type <= iss.ls_type.code;
      lsu_rd_idx  <= iss.rd_idx;
    end
    // Store data only
    if (acc_vld && iss.ls_type.dir.is_store)
      lsu_wdata <= iss.rs2;
  end

  // Codes above SD would decode as byte stores
  assert property (@(posedge clk) disable iff (!rstn) acc_vld |-> iss.ls_type.code <= LS_SD)
    else $error("undefined load/store code issued");

endmodule

// File: csr_alu.sv
// CSR write-data computation and registered CSR write port

`timescale 1ns/1ps

module csr_alu
  import exu_data_pkg::*;
  import exu_isa_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_WIDTH_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rstn,
  exu_issue_if.csr              iss,
  output logic                  csr_vld,
  output logic [DATA_WIDTH-1:0] csr_wdata,
  output csr_idx_t              csr_rd_idx
);

  logic [DATA_WIDTH-1:0] wdata_next;
  logic                  csr_en;

  // I forms use the zero-extended zimm from imm
  always_comb begin
    case (iss.csr_type)
      CSR_RW:  wdata_next = iss.rs1;
      CSR_RS:  wdata_next = iss.csr_data | iss.rs1;
      CSR_RC:  wdata_next = iss.csr_data & ~iss.rs1;
      CSR_RWI: wdata_next = iss.imm;
      CSR_RSI: wdata_next = iss.csr_data | iss.imm;
      CSR_RCI: wdata_next = iss.csr_data & ~iss.imm;
      default: wdata_next = '0;
    endcase
  end

  assign csr_en = iss.vld & (iss.csr_type != CSR_NONE);

  // One-cycle write strobe
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      csr_vld <= 1'b0;
    else
      csr_vld <= csr_en;
  end

  always_ff @(posedge clk) begin
    if (csr_en) begin
      csr_wdata  <= wdata_next;
      csr_rd_idx <= iss.csr_idx;
    end
  end

endmodule

// File: exu_wb.sv
// Register-file result select and registered write-back port

`timescale 1ns/1ps

module exu_wb
  import exu_data_pkg::*;
  import exu_isa_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_WIDTH_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rstn,
  exu_issue_if.wb               iss,
  input  logic [DATA_WIDTH-1:0] arith_result,
  input  pc_t                   link_pc,
  output logic                  gpr_vld,
  output logic [DATA_WIDTH-1:0] gpr_wdata,
  output gpr_idx_t              gpr_rd_idx
);

  logic                  is_jmp;
  logic                  is_csr;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wb_data;

  assign is_jmp = iss.jmp_type != JMP_NONE;
  assign is_csr = iss.csr_type != CSR_NONE;

  // Branches and memory ops write nothing here
  assign wr_en = iss.vld & ((iss.alu_op != ALU_NOP) | is_jmp | is_csr);

  // CSR ops return the old CSR value to rd
  always_comb begin
    if (is_jmp)
      wb_data = DATA_WIDTH'(link_pc);
    else if (is_csr)
      wb_data = iss.csr_data;
    else
      wb_data = arith_result;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      gpr_vld <= 1'b0;
    else
      gpr_vld <= wr_en;
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      gpr_wdata  <= wb_data;
      gpr_rd_idx <= iss.rd_idx;
    end
  end

  // Priority select above needs at most one writing class
  assert property (@(posedge clk) disable iff (!rstn)
                   iss.vld |-> $onehot0({iss.alu_op != ALU_NOP, is_jmp, is_csr}))
    else $error("more than one write-back class issued together");

endmodule

// File: exu_top.sv
// Execute stage top: issue interface, ALU, branch, LSU address, CSR and write-back units

`timescale 1ns/1ps

module exu_top
  import exu_data_pkg::*;
  import exu_isa_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_WIDTH_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rstn,
  // Issued instruction
  input  logic                  in_vld,
  input  pc_t                   in_pc,
  input  logic [DATA_WIDTH-1:0] in_rs1,
  input  logic [DATA_WIDTH-1:0] in_rs2,
  input  logic [DATA_WIDTH-1:0] in_imm,
  input  logic                  in_src2_imm,
  input  logic                  in_word_op,
  input  alu_op_e               in_alu_op,
  input  br_type_e              in_br_type,
  input  jmp_type_e             in_jmp_type,
  input  ls_code_e              in_ls_type,
  input  csr_type_e             in_csr_type,
  input  logic [DATA_WIDTH-1:0] in_csr_data,
  input  gpr_idx_t              in_rd_idx,
  input  csr_idx_t              in_csr_idx,
  // Redirect and misalignment, same cycle
  output logic                  jump_en,
  output pc_t                   next_pc,
  output logic                  l_misa,
  output logic                  s_misa,
  // Registered write-back
  output logic                  gpr_vld,
  output logic [DATA_WIDTH-1:0] gpr_wdata,
  output gpr_idx_t              gpr_rd_idx,
  output logic                  csr_vld,
  output logic [DATA_WIDTH-1:0] csr_wdata,
  output csr_idx_t              csr_rd_idx,
  // Registered memory command
  output logic                  lsu_vld,
  output pc_t                   lsu_addr,
  output logic [DATA_WIDTH-1:0] lsu_wdata,
  output ls_code_e              lsu_ls_type,
  output logic                  lsu_wen,
  output gpr_idx_t              lsu_rd_idx
);

  logic [DATA_WIDTH-1:0] arith_result;
  pc_t                   link_pc;

  // ----------------------------------------------------------
  // Issue bus
  // ----------------------------------------------------------
  exu_issue_if #(.DATA_WIDTH(DATA_WIDTH)) issue_bus ();

  assign issue_bus.vld          = in_vld;
  assign issue_bus.pc           = in_pc;
  assign issue_bus.rs1          = in_rs1;
  assign issue_bus.rs2          = in_rs2;
  assign issue_bus.imm          = in_imm;
  assign issue_bus.src2_imm     = in_src2_imm;
  assign issue_bus.word_op      = in_word_op;
  assign issue_bus.alu_op       = in_alu_op;
  assign issue_bus.br_type      = in_br_type;
  assign issue_bus.jmp_type     = in_jmp_type;
  assign issue_bus.ls_type.code = in_ls_type;
  assign issue_bus.csr_type     = in_csr_type;
  assign issue_bus.csr_data     = in_csr_data;
  assign issue_bus.rd_idx       = in_rd_idx;
  assign issue_bus.csr_idx      = in_csr_idx;

  // ----------------------------------------------------------
  // Units
  // ----------------------------------------------------------
  int_arith #(.DATA_WIDTH(DATA_WIDTH)) int_arith_inst (
    .iss          (issue_bus.arith),
    .arith_result (arith_result)
  );

  branch_unit #(.DATA_WIDTH(DATA_WIDTH)) branch_unit_inst (
    .iss     (issue_bus.branch),
    .jump_en (jump_en),
    .next_pc (next_pc),
    .link_pc (link_pc)
  );

  lsu_agen #(.DATA_WIDTH(DATA_WIDTH)) lsu_agen_inst (
    .clk         (clk),
    .rstn        (rstn),
    .iss         (issue_bus.lsu),
    .l_misa      (l_misa),
    .s_misa      (s_misa),
    .lsu_vld     (lsu_vld),
    .lsu_wen     (lsu_wen),
    .lsu_addr    (lsu_addr),
    .lsu_wdata   (lsu_wdata),
    .lsu_ls_type (lsu_ls_type),
    .lsu_rd_idx  (lsu_rd_idx)
  );

  csr_alu #(.DATA_WIDTH(DATA_WIDTH)) csr_alu_inst (
    .clk        (clk),
    .rstn       (rstn),
    .iss        (issue_bus.csr),
    .csr_vld    (csr_vld),
    .csr_wdata  (csr_wdata),
    .csr_rd_idx (csr_rd_idx)
  );

  exu_wb #(.DATA_WIDTH(DATA_WIDTH)) exu_wb_inst (
    .clk          (clk),
    .rstn         (rstn),
    .iss          (issue_bus.wb),
    .arith_result (arith_result),
    .link_pc      (link_pc),
    .gpr_vld      (gpr_vld),
    .gpr_wdata    (gpr_wdata),
    .gpr_rd_idx   (gpr_rd_idx)
  );

endmodule

// File: tb_exu_top.sv
// Testbench for the execute stage: stimulus table, clock, reset, check task and timeout

`timescale 1ns/1ps

module tb_exu_top
  import exu_data_pkg::*;
  import exu_isa_pkg::*;
();

  localparam int       DW       = 64;
  localparam pc_t      ALU_PC   = 32'h0000_1000;
  localparam pc_t      BR_PC    = 32'h0000_2000;
  localparam pc_t      JMP_PC   = 32'h0000_3000;
  localparam logic [DW-1:0] CSR_OLD = 64'h0000_0000_0000_00F0;
  localparam csr_idx_t CSR_ADDR = 12'h300;

  // One table row of issued fields and expected values
  typedef struct packed {
    pc_t         pc;
    logic [DW-1:0] rs1;
    logic [DW-1:0] rs2;
    logic [DW-1:0] imm;
    logic        src2_imm;
    logic        word_op;
    alu_op_e     alu_op;
    br_type_e    br_type;
    jmp_type_e   jmp_type;
    ls_code_e    ls_type;
    csr_type_e   csr_type;
    logic [DW-1:0] csr_data;
    gpr_idx_t    rd_idx;
    csr_idx_t    csr_idx;
    logic        e_jump;
    pc_t         e_next_pc;
    logic        e_l_misa;
    logic        e_s_misa;
    logic        e_gpr_vld;
    logic [DW-1:0] e_gpr_wdata;
    logic        e_csr_vld;
    logic [DW-1:0] e_csr_wdata;
    logic        e_lsu_vld;
    pc_t         e_lsu_addr;
    logic        e_lsu_wen;
  } entry_t;

  logic          clk;
  logic          rstn;
  logic          in_vld;
  pc_t           in_pc;
  logic [DW-1:0] in_rs1;
  logic [DW-1:0] in_rs2;
  logic [DW-1:0] in_imm;
  logic          in_src2_imm;
  logic          in_word_op;
  alu_op_e       in_alu_op;
  br_type_e      in_br_type;
  jmp_type_e     in_jmp_type;
  ls_code_e      in_ls_type;
  csr_type_e     in_csr_type;
  logic [DW-1:0] in_csr_data;
  gpr_idx_t      in_rd_idx;
  csr_idx_t      in_csr_idx;
  logic          jump_en;
  pc_t           next_pc;
  logic          l_misa;
  logic          s_misa;
  logic          gpr_vld;
  logic [DW-1:0] gpr_wdata;
  gpr_idx_t      gpr_rd_idx;
  logic          csr_vld;
  logic [DW-1:0] csr_wdata;
  csr_idx_t      csr_rd_idx;
  logic          lsu_vld;
  pc_t           lsu_addr;
  logic [DW-1:0] lsu_wdata;
  ls_code_e      lsu_ls_type;
  logic          lsu_wen;
  gpr_idx_t      lsu_rd_idx;

  entry_t entries[$];
  entry_t idle_e;
  int     cycles;
  int     cur_entry;

  exu_top #(.DATA_WIDTH(DW)) exu_top_inst (.*);

  // ----------------------------------------------------------
  // Clock and timeout
  // ----------------------------------------------------------
  always #50 clk = ~clk;

  // Limit covers reset, two cycles per row and a margin
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= 10 + 2 * entries.size() + 20) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycles);
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // ----------------------------------------------------------
  // Check and table helpers
  // ----------------------------------------------------------
  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns entry %0d %s: got %h, expected %h",
               $time, cur_entry, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Not-taken default falls through to pc + 4
  function automatic entry_t blank_entry(input pc_t pc);
    entry_t e;
    e = '0;
    e.pc = pc;
    e.e_next_pc = pc + 32'd4;
    return e;
  endfunction

  task automatic add_alu(input alu_op_e op, input logic word, input logic use_imm,
                         input logic [63:0] a, input logic [63:0] b,
                         input gpr_idx_t rd, input logic [63:0] exp);
    entry_t e;
    e = blank_entry(ALU_PC);
    e.alu_op = op;
    e.word_op = word;
    e.src2_imm = use_imm;
    e.rs1 = a;
    if (use_imm)
      e.imm = b;
    else
      e.rs2 = b;
    e.rd_idx = rd;
    e.e_gpr_vld = 1'b1;
    e.e_gpr_wdata = exp;
    entries.push_back(e);
  endtask

  task automatic add_branch(input br_type_e br, input logic [63:0] a, input logic [63:0] b,
                            input logic [63:0] imm, input logic taken, input pc_t exp_pc);
    entry_t e;
    e = blank_entry(BR_PC);
    e.br_type = br;
    e.rs1 = a;
    e.rs2 = b;
    e.imm = imm;
    e.rd_idx = 5'd0;
    e.e_jump = taken;
    e.e_next_pc = exp_pc;
    entries.push_back(e);
  endtask

  task automatic add_jump(input jmp_type_e j, input logic [63:0] a, input logic [63:0] imm,
                          input gpr_idx_t rd, input pc_t exp_pc, input logic [63:0] exp_link);
    entry_t e;
    e = blank_entry(JMP_PC);
    e.jmp_type = j;
    e.rs1 = a;
    e.imm = imm;
    e.rd_idx = rd;
    e.e_jump = 1'b1;
    e.e_next_pc = exp_pc;
    e.e_gpr_vld = 1'b1;
    e.e_gpr_wdata = exp_link;
    entries.push_back(e);
  endtask

  // Store data rides on rs2
  task automatic add_mem(input ls_code_e ls, input logic [63:0] a, input logic [63:0] imm,
                         input logic [63:0] wdata, input gpr_idx_t rd, input pc_t exp_addr,
                         input logic wen, input logic lm, input logic sm);
    entry_t e;
    e = blank_entry(ALU_PC);
    e.ls_type = ls;
    e.rs1 = a;
    e.rs2 = wdata;
    e.imm = imm;
    e.rd_idx = rd;
    e.e_l_misa = lm;
    e.e_s_misa = sm;
    e.e_lsu_vld = 1'b1;
    e.e_lsu_addr = exp_addr;
    e.e_lsu_wen = wen;
    entries.push_back(e);
  endtask

  // Old CSR value always returns to rd
  task automatic add_csr(input csr_type_e c, input logic [63:0] a, input logic [63:0] imm,
                         input gpr_idx_t rd, input logic [63:0] exp);
    entry_t e;
    e = blank_entry(ALU_PC);
    e.csr_type = c;
    e.rs1 = a;
    e.imm = imm;
    e.csr_data = CSR_OLD;
    e.csr_idx = CSR_ADDR;
    e.rd_idx = rd;
    e.e_csr_vld = 1'b1;
    e.e_csr_wdata = exp;
    e.e_gpr_vld = 1'b1;
    e.e_gpr_wdata = CSR_OLD;
    entries.push_back(e);
  endtask

  task automatic build_table();
    // ALU register and immediate forms
    add_alu(ALU_ADD,   1'b0, 1'b0, 64'd5, 64'd7, 5'd1, 64'd12);
    add_alu(ALU_SUB,   1'b0, 1'b0, 64'd3, 64'd5, 5'd2, 64'hFFFF_FFFF_FFFF_FFFE);
    add_alu(ALU_SLT,   1'b0, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 5'd3, 64'd1);
    add_alu(ALU_SLTU,  1'b0, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 5'd4, 64'd0);
    add_alu(ALU_XOR,   1'b0, 1'b1, 64'hF0F0, 64'h0FF0, 5'd5, 64'hFF00);
    add_alu(ALU_AND,   1'b0, 1'b0, 64'hF0F0, 64'h0FF0, 5'd21, 64'h00F0);
    add_alu(ALU_OR,    1'b0, 1'b1, 64'hF0F0, 64'h0FF0, 5'd22, 64'hFFF0);
    add_alu(ALU_SLL,   1'b0, 1'b1, 64'd1, 64'd40, 5'd6, 64'h0000_0100_0000_0000);
    add_alu(ALU_SRA,   1'b0, 1'b0, 64'h8000_0000_0000_0000, 64'd4, 5'd7,
            64'hF800_0000_0000_0000);
    // W forms sign-extend bit 31
    add_alu(ALU_ADD,   1'b1, 1'b1, 64'h7FFF_FFFF, 64'd1, 5'd8, 64'hFFFF_FFFF_8000_0000);
    add_alu(ALU_SRL,   1'b1, 1'b1, 64'hFFFF_FFFF_8000_0000, 64'd4, 5'd9, 64'h0800_0000);
    add_alu(ALU_SRA,   1'b1, 1'b0, 64'h8000_0000, 64'd8, 5'd10, 64'hFFFF_FFFF_FF80_0000);
    add_alu(ALU_LUI,   1'b0, 1'b1, 64'd0, 64'hFFFF_FFFF_ABCD_E000, 5'd11,
            64'hFFFF_FFFF_ABCD_E000);
    add_alu(ALU_AUIPC, 1'b0, 1'b1, 64'd0, 64'h2000, 5'd12, 64'h3000);
    // Branch pairs at 0x2000 with the taken case first
    add_branch(BR_BEQ,  64'd5, 64'd5, 64'h40, 1'b1, 32'h2040);
    add_branch(BR_BEQ,  64'd5, 64'd6, 64'h40, 1'b0, 32'h2004);
    add_branch(BR_BNE,  64'd5, 64'd6, 64'hFFFF_FFFF_FFFF_FFF0, 1'b1, 32'h1FF0);
    add_branch(BR_BNE,  64'd5, 64'd5, 64'h40, 1'b0, 32'h2004);
    add_branch(BR_BLT,  64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'h40, 1'b1, 32'h2040);
    add_branch(BR_BLT,  64'd1, 64'hFFFF_FFFF_FFFF_FFFF, 64'h40, 1'b0, 32'h2004);
    add_branch(BR_BGE,  64'd1, 64'hFFFF_FFFF_FFFF_FFFF, 64'h40, 1'b1, 32'h2040);
    add_branch(BR_BGE,  64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'h40, 1'b0, 32'h2004);
    add_branch(BR_BLTU, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF, 64'h40, 1'b1, 32'h2040);
    add_branch(BR_BLTU, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'h40, 1'b0, 32'h2004);
    add_branch(BR_BGEU, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'h40, 1'b1, 32'h2040);
    add_branch(BR_BGEU, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF, 64'h40, 1'b0, 32'h2004);
    // Jumps at 0x3000 and a JALR target with bit 0 kept
    add_jump(JMP_JAL,  64'd0, 64'h100, 5'd1, 32'h3100, 64'h3004);
    add_jump(JMP_JALR, 64'h8001, 64'h10, 5'd31, 32'h8011, 64'h3004);
    // Two aligned then two misaligned memory accesses
    add_mem(LS_LD, 64'h1000, 64'h18, 64'd0, 5'd13, 32'h1018, 1'b0, 1'b0, 1'b0);
    add_mem(LS_SW, 64'h2000, 64'hFFFF_FFFF_FFFF_FFFC, 64'hDEAD_BEEF_1234_5678, 5'd0,
            32'h1FFC, 1'b1, 1'b0, 1'b0);
    add_mem(LS_LH, 64'h1001, 64'd0, 64'd0, 5'd14, 32'h1001, 1'b0, 1'b1, 1'b0);
    add_mem(LS_SD, 64'h1004, 64'd0, 64'h0123_4567_89AB_CDEF, 5'd0, 32'h1004,
            1'b1, 1'b0, 1'b1);
    // CSR forms against old value 0xF0
    add_csr(CSR_RW,  64'h5A, 64'd0, 5'd15, 64'h5A);
    add_csr(CSR_RS,  64'h0F, 64'd0, 5'd16, 64'hFF);
    add_csr(CSR_RC,  64'h30, 64'd0, 5'd17, 64'hC0);
    add_csr(CSR_RWI, 64'd0, 64'h1F, 5'd18, 64'h1F);
    add_csr(CSR_RSI, 64'd0, 64'h03, 5'd19, 64'hF3);
    add_csr(CSR_RCI, 64'd0, 64'h10, 5'd20, 64'hE0);
  endtask

  // ----------------------------------------------------------
  // Drive and compare
  // ----------------------------------------------------------
  task automatic apply_entry(input entry_t e, input logic vld);
    in_vld      = vld;
    in_pc       = e.pc;
    in_rs1      = e.rs1;
    in_rs2      = e.rs2;
    in_imm      = e.imm;
    in_src2_imm = e.src2_imm;
    in_word_op  = e.word_op;
    in_alu_op   = e.alu_op;
    in_br_type  = e.br_type;
    in_jmp_type = e.jmp_type;
    in_ls_type  = e.ls_type;
    in_csr_type = e.csr_type;
    in_csr_data = e.csr_data;
    in_rd_idx   = e.rd_idx;
    in_csr_idx  = e.csr_idx;
  endtask

  // Same-cycle outputs
  task automatic check_comb(input entry_t e);
    check_value("jump_en", 64'(jump_en), 64'(e.e_jump));
    check_value("next_pc", 64'(next_pc), 64'(e.e_next_pc));
    check_value("l_misa", 64'(l_misa), 64'(e.e_l_misa));
    check_value("s_misa", 64'(s_misa), 64'(e.e_s_misa));
  endtask

  // Registered outputs one cycle after issue
  task automatic check_regs(input entry_t e);
    check_value("gpr_vld", 64'(gpr_vld), 64'(e.e_gpr_vld));
    if (e.e_gpr_vld) begin
      check_value("gpr_wdata", gpr_wdata, e.e_gpr_wdata);
      check_value("gpr_rd_idx", 64'(gpr_rd_idx), 64'(e.rd_idx));
    end
    check_value("csr_vld", 64'(csr_vld), 64'(e.e_csr_vld));
    if (e.e_csr_vld) begin
      check_value("csr_wdata", csr_wdata, e.e_csr_wdata);
      check_value("csr_rd_idx", 64'(csr_rd_idx), 64'(e.csr_idx));
    end
    check_value("lsu_vld", 64'(lsu_vld), 64'(e.e_lsu_vld));
    if (e.e_lsu_vld) begin
      check_value("lsu_addr", 64'(lsu_addr), 64'(e.e_lsu_addr));
      check_value("lsu_ls_type", 64'(lsu_ls_type), 64'(e.ls_type));
      check_value("lsu_rd_idx", 64'(lsu_rd_idx), 64'(e.rd_idx));
      check_value("lsu_wen", 64'(lsu_wen), 64'(e.e_lsu_wen));
      if (e.e_lsu_wen)
        check_value("lsu_wdata", lsu_wdata, e.rs2);
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    cycles = 0;
    cur_entry = -1;
    idle_e = '0;
    apply_entry(idle_e, 1'b0);
    build_table();

    repeat (10) @(posedge clk);
    #5 rstn = 1'b1;

    // All strobes low while idle after reset
    @(negedge clk);
    check_comb(idle_e);
    check_regs(idle_e);
    check_value("lsu_wen", 64'(lsu_wen), 64'd0);

    // One row per cycle with the previous row still in the registers
    for (int i = 0; i < entries.size(); i++) begin
      @(posedge clk);
      #5 apply_entry(entries[i], 1'b1);
      @(negedge clk);
      cur_entry = i;
      check_comb(entries[i]);
      if (i > 0) begin
        cur_entry = i - 1;
        check_regs(entries[i-1]);
      end
    end

    // Drain the last row
    @(posedge clk);
    #5 apply_entry(idle_e, 1'b0);
    @(negedge clk);
    cur_entry = entries.size() - 1;
    check_regs(entries[entries.size()-1]);
    check_comb(idle_e);

    $display("Test passed");
    $finish;
  end

endmodule

// File: exu_top.f
exu_data_pkg.sv
exu_isa_pkg.sv
exu_issue_if.sv
int_arith.sv
branch_unit.sv
lsu_agen.sv
csr_alu.sv
exu_wb.sv
exu_top.sv
tb_exu_top.sv

// File: run.sh
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f exu_top.f \
  --top-module tb_exu_top \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

./obj_dir/Vtb_exu_top
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0
